// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := lspcVramTb
FILELIST  := sources.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: hw/lspcBusDecode.sv
/*
 * LSPC bus decode stage
 * Wishbone classic slave front end. Turns each bus cycle into a
 * single pipeline command, then holds the cycle open until the
 * memory stage reports completion and returns the acknowledge.
 */

`timescale 1ns/10ps
`default_nettype none

module lspcBusDecode import lspcPkg::*; (
	input  wire logic     CLK,
	input  wire logic     nRESETP,
	input  wire logic     wbCyc,
	input  wire logic     wbStb,
	input  wire logic     wbWe,
	input  wire regSelE   wbAdr,
	input  wire vramWordT wbDatW,
	input  wire logic     done,
	input  wire vramWordT rdWord,
	output logic          wbAck,
	output vramWordT      wbDatR,
	output logic          cmdValid,
	output cmdE           cmd,
	output vramWordT      cmdData
);

	// Cycle in progress from sampling edge until strobe release
	logic busy;
	// Completion returned and waiting for strobe low
	logic ackSeen;
	logic accept;
	cmdE reqCmd;

	assign accept = !busy && wbCyc && wbStb;

	// ====================
	// Command decode
	// ====================
	always_comb begin
		case (wbAdr)
			RegVramAddr: reqCmd = wbWe ? CmdLoadAddr : CmdReadAddr;
			RegVramRw: reqCmd = wbWe ? CmdWriteData : CmdReadData;
			RegVramMod: reqCmd = wbWe ? CmdLoadMod : CmdReadMod;
			// Empty select reads as zero
			RegNone: reqCmd = CmdNop;
			default: reqCmd = CmdNop;
		endcase
	end

	// ====================
	// Cycle tracking
	// ====================
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			busy <= 1'b0;
			ackSeen <= 1'b0;
			cmdValid <= 1'b0;
			cmd <= CmdIdle;
		end else begin
			// One-cycle command pulse
			cmdValid <= accept;
			if (accept) begin
				busy <= 1'b1;
				cmd <= reqCmd;
			end
			if (done)
				ackSeen <= 1'b1;
			// Master has dropped the strobe after the ack
			if (ackSeen && !wbStb) begin
				busy <= 1'b0;
				ackSeen <= 1'b0;
			end
		end
	end

	// Write data rides along with the command
	always_ff @(posedge CLK) begin
		if (accept)
			cmdData <= wbDatW;
	end

	// Ack straight from the memory stage
	assign wbAck = done;
	// Read bus idles at zero
	assign wbDatR = done ? rdWord : '0;

endmodule

`default_nettype wire

// File: hw/lspcPkg.sv
/*
 * LSPC VRAM access definitions
 * Word and address widths, VRAM zone geometry, the CPU register
 * select encoding and the command set passed down the VRAM pipeline
 */

`default_nettype none

package lspcPkg;

	// ====================
	// Widths
	// ====================
	localparam int WordBits = 16;
	localparam int RegSelBits = 2;

	// Slow zone indexed by address bits 9..0, fast zone by 10..0
	localparam int LowZoneBits = 10;
	localparam int HighZoneBits = 11;
	localparam int LowZoneWords = 1 << LowZoneBits;
	localparam int HighZoneWords = 1 << HighZoneBits;

	// Address bit 15 picks the fast zone
	localparam int ZoneSelBit = 15;

	typedef logic [WordBits-1:0] vramWordT;
	typedef logic [WordBits-1:0] vramAddrT;

	// ====================
	// Encodings
	// ====================
	// Same order as the CPU register select lines
	typedef enum logic [RegSelBits-1:0] {
		RegVramAddr = 2'd0,
		RegVramRw   = 2'd1,
		RegVramMod  = 2'd2,
		RegNone     = 2'd3
	} regSelE;

	// Operations carried from decode to memory
	typedef enum logic [2:0] {
		CmdIdle,
		CmdLoadAddr,
		CmdLoadMod,
		CmdWriteData,
		CmdReadData,
		CmdReadAddr,
		CmdReadMod,
		CmdNop
	} cmdE;

endpackage

`default_nettype wire

// File: hw/lspcVramAddr.sv
/*
 * LSPC VRAM address stage
 * Holds VRAMADDR and VRAMMOD, hands memory operations to the
 * bank stage and steps the address by VRAMMOD after data writes
 */

`timescale 1ns/10ps
`default_nettype none

module lspcVramAddr import lspcPkg::*; (
	input  wire logic     CLK,
	input  wire logic     nRESETP,
	input  wire logic     cmdValid,
	input  wire cmdE      cmd,
	input  wire vramWordT cmdData,
	output logic          memValid,
	output cmdE           memCmd,
	output vramAddrT      memAddr,
	output vramWordT      memData
);

	// CPU visible registers
	vramAddrT vramAddr;
	vramWordT vramMod;

	// ====================
	// Register updates
	// ====================
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramAddr <= '0;
			vramMod <= '0;
			memValid <= 1'b0;
			memCmd <= CmdIdle;
		end else begin
			memValid <= cmdValid;
			if (cmdValid) begin
				memCmd <= cmd;
				case (cmd)
					CmdLoadAddr: vramAddr <= cmdData;
					CmdLoadMod: vramMod <= cmdData;
					// Post-write step wrapping at 16 bits
					CmdWriteData: vramAddr <= vramAddr + vramMod;
					default: ;
				endcase
			end
		end
	end

	// ====================
	// Memory request payload
	// ====================
	// Address is taken before the post-write step
	always_ff @(posedge CLK) begin
		if (cmdValid) begin
			memAddr <= vramAddr;
			case (cmd)
				// Register readback goes through the data lane
				CmdReadAddr: memData <= vramAddr;
				CmdReadMod: memData <= vramMod;
				default: memData <= cmdData;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/lspcVramBanks.sv
/*
 * LSPC VRAM bank stage
 * Slow zone of 1024 words and fast zone of 2048 words, both
 * mirrored over the address space. Produces the read word and
 * a one-cycle completion pulse per command.
 */

`timescale 1ns/10ps
`default_nettype none

module lspcVramBanks import lspcPkg::*; (
	input  wire logic     CLK,
	input  wire logic     nRESETP,
	input  wire logic     memValid,
	input  wire cmdE      memCmd,
	input  wire vramAddrT memAddr,
	input  wire vramWordT memData,
	output logic          done,
	output vramWordT      rdWord
);

	// ====================
	// Storage
	// ====================
	vramWordT slowZone [LowZoneWords];
	vramWordT fastZone [HighZoneWords];

	logic fastSel;
	logic [LowZoneBits-1:0] slowIdx;
	logic [HighZoneBits-1:0] fastIdx;
	logic wrEn;

	// Upper bits dropped, so both zones mirror
	assign fastSel = memAddr[ZoneSelBit];
	assign slowIdx = memAddr[LowZoneBits-1:0];
	assign fastIdx = memAddr[HighZoneBits-1:0];
	assign wrEn = memValid && (memCmd == CmdWriteData);

	// Zone write
	always_ff @(posedge CLK) begin
		if (wrEn) begin
			if (fastSel)
				fastZone[fastIdx] <= memData;
			else
				slowZone[slowIdx] <= memData;
		end
	end

	// ====================
	// Result
	// ====================
	always_ff @(posedge CLK) begin
		if (memValid) begin
			case (memCmd)
				CmdReadData: rdWord <= fastSel ? fastZone[fastIdx] : slowZone[slowIdx];
				// Register values already on the data lane
				CmdReadAddr, CmdReadMod: rdWord <= memData;
				// Writes, loads and the empty select
				default: rdWord <= '0;
			endcase
		end
	end

	// One pulse per command
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP)
			done <= 1'b0;
		else
			done <= memValid;
	end

endmodule

`default_nettype wire

// File: hw/lspcVramTop.sv
/*
 * LSPC CPU to VRAM path
 * Wishbone classic slave with VRAMADDR, VRAMRW and VRAMMOD,
 * built as decode, address and memory stages
 */

`timescale 1ns/10ps
`default_nettype none

module lspcVramTop import lspcPkg::*; (
	input  wire logic     CLK,
	input  wire logic     nRESETP,
	input  wire logic     wbCyc,
	input  wire logic     wbStb,
	input  wire logic     wbWe,
	input  wire regSelE   wbAdr,
	input  wire vramWordT wbDatW,
	output vramWordT      wbDatR,
	output logic          wbAck
);

	// ====================
	// Stage links
	// ====================
	// Decode to address
	logic cmdValid;
	cmdE cmd;
	vramWordT cmdData;
	// Address to memory
	logic memValid;
	cmdE memCmd;
	vramAddrT memAddr;
	vramWordT memData;
	// Memory back to decode
	logic done;
	vramWordT rdWord;

	lspcBusDecode busDecode_i (
		.CLK      (CLK),
		.nRESETP  (nRESETP),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb),
		.wbWe     (wbWe),
		.wbAdr    (wbAdr),
		.wbDatW   (wbDatW),
		.done     (done),
		.rdWord   (rdWord),
		.wbAck    (wbAck),
		.wbDatR   (wbDatR),
		.cmdValid (cmdValid),
		.cmd      (cmd),
		.cmdData  (cmdData)
	);

	lspcVramAddr vramAddr_i (
		.CLK      (CLK),
		.nRESETP  (nRESETP),
		.cmdValid (cmdValid),
		.cmd      (cmd),
		.cmdData  (cmdData),
		.memValid (memValid),
		.memCmd   (memCmd),
		.memAddr  (memAddr),
		.memData  (memData)
	);

	lspcVramBanks vramBanks_i (
		.CLK      (CLK),
		.nRESETP  (nRESETP),
		.memValid (memValid),
		.memCmd   (memCmd),
		.memAddr  (memAddr),
		.memData  (memData),
		.done     (done),
		.rdWord   (rdWord)
	);

endmodule

`default_nettype wire

// File: sim/lspcClockGen.sv
/*
 * Testbench clock and reset
 * 10 ns clock, active-low reset held for the first 4 cycles
 */

`timescale 1ns/10ps
`default_nettype none

module lspcClockGen (
	output logic CLK,
	output logic nRESETP
);

	localparam int HalfPeriod = 5;
	localparam int ResetCycles = 4;

	// Free-running clock
	initial begin
		CLK = 1'b0;
		forever #HalfPeriod CLK = ~CLK;
	end

	initial begin
		nRESETP = 1'b0;
		repeat (ResetCycles) @(posedge CLK);
		// Release between edges
		#2 nRESETP = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/lspcVramTb.sv
/*
 * LSPC VRAM path testbench
 * Builds a table of Wishbone transfers with expected read data from
 * a reference VRAM model, then runs it against the DUT and checks
 * data, acknowledge latency and idle read bus on every transfer
 */

`timescale 1ns/10ps
`default_nettype none

module lspcVramTb import lspcPkg::*; ();

	localparam int AckTimeout = 20;
	localparam int ResetTimeout = 20;
	localparam int AckLatency = 3;

	logic CLK;
	logic nRESETP;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	regSelE wbAdr;
	vramWordT wbDatW;
	vramWordT wbDatR;
	logic wbAck;

	integer seed = 81751;

	// ====================
	// Stimulus table
	// ====================
	string tName [$];
	logic tWe [$];
	regSelE tSel [$];
	vramWordT tData [$];
	vramWordT tExp [$];

	// Reference model state
	vramAddrT modelAddr;
	vramWordT modelMod;
	vramWordT slowModel [LowZoneWords];
	vramWordT fastModel [HighZoneWords];

	lspcClockGen clockGen_i (
		.CLK     (CLK),
		.nRESETP (nRESETP)
	);

	lspcVramTop dut_i (
		.CLK     (CLK),
		.nRESETP (nRESETP),
		.wbCyc   (wbCyc),
		.wbStb   (wbStb),
		.wbWe    (wbWe),
		.wbAdr   (wbAdr),
		.wbDatW  (wbDatW),
		.wbDatR  (wbDatR),
		.wbAck   (wbAck)
	);

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string name, input vramWordT expVal, input vramWordT actVal);
		if (actVal !== expVal)
			abortRun($sformatf("CHECK FAILED %s expected %h actual %h", name, expVal, actVal));
	endtask

	task automatic checkLatency(input string name, input int expCycles, input int actCycles);
		if (actCycles != expCycles)
			abortRun($sformatf("CHECK FAILED %s latency expected %0d actual %0d",
				name, expCycles, actCycles));
	endtask

	// Bit 15 picks the zone and upper index bits are ignored
	function automatic vramWordT readModel(input vramAddrT addr);
		if (addr[ZoneSelBit])
			return fastModel[addr[HighZoneBits-1:0]];
		return slowModel[addr[LowZoneBits-1:0]];
	endfunction

	// Append one transfer and advance the model
	task automatic addEntry(input string name, input logic we, input regSelE sel,
			input vramWordT data);
		vramWordT expVal;
		expVal = '0;
		case (sel)
			RegVramAddr: begin
				if (we)
					modelAddr = data;
				else
					expVal = modelAddr;
			end
			RegVramMod: begin
				if (we)
					modelMod = data;
				else
					expVal = modelMod;
			end
			RegVramRw: begin
				if (we) begin
					if (modelAddr[ZoneSelBit])
						fastModel[modelAddr[HighZoneBits-1:0]] = data;
					else
						slowModel[modelAddr[LowZoneBits-1:0]] = data;
					// Step after write with 16-bit wrap
					modelAddr = modelAddr + modelMod;
				end else begin
					expVal = readModel(modelAddr);
				end
			end
			default: expVal = '0;
		endcase
		tName.push_back(name);
		tWe.push_back(we);
		tSel.push_back(sel);
		tData.push_back(data);
		tExp.push_back(expVal);
	endtask

	// ====================
	// Bus transfer
	// ====================
	// Entered and left on a falling edge
	task automatic busTransfer(input int idx);
		int cycles;
		vramWordT got;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = tWe[idx];
		wbAdr = tSel[idx];
		wbDatW = tData[idx];
		cycles = 0;
		do begin
			@(negedge CLK);
			cycles++;
			// Read bus idles at zero
			if (!wbAck)
				checkWord({tName[idx], " idle"}, '0, wbDatR);
		end while (!wbAck && cycles < AckTimeout);
		if (!wbAck)
			abortRun($sformatf("No acknowledge from the DUT within %0d cycles in %s",
				AckTimeout, tName[idx]));
		checkLatency(tName[idx], AckLatency, cycles);
		got = wbDatR;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbDatW = '0;
		checkWord(tName[idx], tExp[idx], got);
		@(negedge CLK);
		if (wbAck)
			abortRun($sformatf("Acknowledge held longer than one cycle in %s", tName[idx]));
		checkWord({tName[idx], " after ack"}, '0, wbDatR);
		// Decode frees up one cycle later
		@(negedge CLK);
	endtask

	initial begin
		int i;
		int waitCount;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = RegNone;
		wbDatW = '0;
		modelAddr = '0;
		modelMod = '0;

		// Register readback and empty select
		addEntry("addr load", 1'b1, RegVramAddr, 16'h1234);
		addEntry("addr read", 1'b0, RegVramAddr, '0);
		addEntry("mod load", 1'b1, RegVramMod, 16'h0003);
		addEntry("mod read", 1'b0, RegVramMod, '0);
		addEntry("none write", 1'b1, RegNone, vramWordT'($random(seed)));
		addEntry("none read", 1'b0, RegNone, '0);
		// Empty select write leaves both registers alone
		addEntry("none addr read", 1'b0, RegVramAddr, '0);
		addEntry("none mod read", 1'b0, RegVramMod, '0);

		// Burst with step 1, then read back in place
		addEntry("burst mod", 1'b1, RegVramMod, 16'h0001);
		addEntry("burst addr", 1'b1, RegVramAddr, 16'h0100);
		for (i = 0; i < 6; i++)
			addEntry($sformatf("burst wr %0d", i), 1'b1, RegVramRw, vramWordT'($random(seed)));
		addEntry("burst reload", 1'b1, RegVramAddr, 16'h0100);
		addEntry("burst mod0", 1'b1, RegVramMod, 16'h0000);
		for (i = 0; i < 6; i++) begin
			addEntry($sformatf("burst rd %0d", i), 1'b0, RegVramRw, '0);
			addEntry($sformatf("burst step %0d", i), 1'b1, RegVramAddr, 16'h0101 + i[15:0]);
		end
		addEntry("burst addr read", 1'b0, RegVramAddr, '0);

		// Negative step across address zero
		addEntry("neg mod", 1'b1, RegVramMod, 16'hFFFF);
		addEntry("neg addr", 1'b1, RegVramAddr, 16'h0002);
		for (i = 0; i < 5; i++)
			addEntry($sformatf("neg wr %0d", i), 1'b1, RegVramRw, vramWordT'($random(seed)));
		addEntry("neg wrap read", 1'b0, RegVramAddr, '0);
		addEntry("neg mod0", 1'b1, RegVramMod, 16'h0000);
		for (i = 0; i < 5; i++) begin
			addEntry($sformatf("neg seek %0d", i), 1'b1, RegVramAddr, 16'h0002 - i[15:0]);
			addEntry($sformatf("neg rd %0d", i), 1'b0, RegVramRw, '0);
		end

		// Zone split and mirroring
		addEntry("slow seek", 1'b1, RegVramAddr, 16'h0040);
		addEntry("slow wr", 1'b1, RegVramRw, vramWordT'($random(seed)));
		addEntry("fast seek", 1'b1, RegVramAddr, 16'h8040);
		addEntry("fast wr", 1'b1, RegVramRw, vramWordT'($random(seed)));
		addEntry("slow reseek", 1'b1, RegVramAddr, 16'h0040);
		addEntry("slow rd", 1'b0, RegVramRw, '0);
		addEntry("fast reseek", 1'b1, RegVramAddr, 16'h8040);
		addEntry("fast rd", 1'b0, RegVramRw, '0);
		addEntry("slow mirror seek", 1'b1, RegVramAddr, 16'h7C40);
		addEntry("slow mirror rd", 1'b0, RegVramRw, '0);
		addEntry("fast mirror seek", 1'b1, RegVramAddr, 16'hF840);
		addEntry("fast mirror rd", 1'b0, RegVramRw, '0);

		// Wait for reset release
		waitCount = 0;
		while (!nRESETP && waitCount < ResetTimeout) begin
			@(negedge CLK);
			waitCount++;
		end
		if (!nRESETP)
			abortRun("Reset was never released");
		@(negedge CLK);

		for (i = 0; i < tName.size(); i++)
			busTransfer(i);

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
hw/lspcPkg.sv
hw/lspcBusDecode.sv
hw/lspcVramAddr.sv
hw/lspcVramBanks.sv
hw/lspcVramTop.sv
sim/lspcClockGen.sv
sim/lspcVramTb.sv
